// ==== sources.f ====
src/alut_regmap_pkg.sv
src/alut_table_pkg.sv
src/alut_reg_bank.sv
src/alut_timer.sv
src/alut_mem.sv
src/alut_addr_checker.sv
src/alut_age_checker.sv
src/alut.sv
test/alut_tb.sv

// ==== Bender.yml ====
package:
  name: alut

sources:
  - src/alut_regmap_pkg.sv
  - src/alut_table_pkg.sv
  - src/alut_reg_bank.sv
  - src/alut_timer.sv
  - src/alut_mem.sv
  - src/alut_addr_checker.sv
  - src/alut_age_checker.sv
  - src/alut.sv
  - target: test
    files:
      - test/alut_tb.sv

// ==== test/alut_tb.sv ====
// alut testbench
`default_nettype none

module alut_tb
   import alut_regmap_pkg::*, alut_table_pkg::*;
();

   timeunit 1ns;
   timeprecision 100ps;

   localparam int ENTRIES    = 8;
   localparam int IDX_W      = $clog2(ENTRIES);
   localparam int CLK_PERIOD = 20;
   localparam int MAX_CYCLES = 20000; // far beyond the whole sequence
   localparam int TIMER_DIV  = 3;     // curr_time ticks every 4 clocks
   localparam int TIMER_GAP  = 100;   // clocks between the two time samples
   localparam int AGE_LIMIT  = 20;    // best-before age in ticks
   localparam int AGE_WAIT   = 500;   // lets early entries age well past it
   localparam logic [47:0] BCAST = 48'hffff_ffff_ffff;

   logic        pclk22;
   logic        n_p_reset22;
   logic        psel;
   logic        penable;
   logic        pwrite;
   logic [6:0]  paddr;
   logic [31:0] pwdata;
   logic [31:0] prdata;

   // reference table, stamp is a lower bound
   logic              ref_valid [ENTRIES];
   logic [47:0]       ref_mac   [ENTRIES];
   logic [1:0]        ref_port  [ENTRIES];
   logic [31:0]       ref_stamp [ENTRIES];
   logic [47:0]       exp_inv_mac;
   logic [1:0]        exp_inv_port;
   logic [47:0]       own_mac;
   integer            seed;
   int                cycles = 0;

   alut #(.ENTRIES(ENTRIES)) u_dut (
      .pclk22, .n_p_reset22, .psel, .penable, .pwrite, .paddr, .pwdata, .prdata
   );

   initial
   begin
      pclk22 = 1'b0;
      forever #(CLK_PERIOD / 2) pclk22 = ~pclk22;
   end

   // ---------------------------------------------------------------------
   // error exit and checks
   // ---------------------------------------------------------------------
   task automatic stop_on_error(input string msg);
      $display("%s", msg);
      $display("Something failed");
      $fatal(1);
   endtask

   task automatic expect_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
      assert (got === exp)
      else
         stop_on_error($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
   endtask

   // bus parks at zero outside read access phases
   a_prdata_idle : assert property (@(posedge pclk22) disable iff (!n_p_reset22)
      !(psel && penable && !pwrite) |-> prdata == '0)
      else
         stop_on_error($sformatf("MISMATCH prdata got %h expected %h", $sampled(prdata), 32'h0));

   always @(posedge pclk22)
   begin
      cycles <= cycles + 1;
      if (cycles == MAX_CYCLES)
         stop_on_error($sformatf("timeout, run still going after %0d cycles", MAX_CYCLES));
   end

   // ---------------------------------------------------------------------
   // apb access
   // ---------------------------------------------------------------------
   task automatic write_reg(input logic [6:0] addr, input logic [31:0] data);
      @(posedge pclk22);
      #1;
      psel    = 1'b1;  // setup
      pwrite  = 1'b1;
      penable = 1'b0;
      paddr   = addr;
      pwdata  = data;
      @(posedge pclk22);
      #1;
      penable = 1'b1;  // access, lands on next edge
      @(posedge pclk22);
      #1;
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
   endtask

   task automatic read_reg(input logic [6:0] addr, output logic [31:0] data);
      @(posedge pclk22);
      #1;
      psel    = 1'b1;
      pwrite  = 1'b0;
      penable = 1'b0;
      paddr   = addr;
      @(posedge pclk22);
      #1;
      penable = 1'b1;
      data    = prdata;   // registered in setup, stable all access phase
      @(posedge pclk22);
      #1;
      psel    = 1'b0;
      penable = 1'b0;
   endtask

   task automatic check_reg(input logic [6:0] addr, input logic [31:0] exp);
      logic [31:0] data;
      read_reg(addr, data);
      expect_eq($sformatf("prdata at offset %h", addr), data, exp);
   endtask

   task automatic write_mac(input logic [6:0] lo, input logic [6:0] hi, input logic [47:0] mac);
      write_reg(lo, mac[31:0]);
      write_reg(hi, {16'd0, mac[47:32]});
   endtask

   // poll until neither check nor sweep is busy
   task automatic wait_idle(output logic [31:0] status);
      status = 32'h1;
      while (status[ST_ACTIVE] || status[ST_INVAL])
         read_reg(AL_STATUS, status);
   endtask

   // random unicast address aimed at one table index
   task automatic make_mac(input int idx, output logic [47:0] mac);
      logic [31:0] r0;
      logic [31:0] r1;
      r0  = $random(seed);
      r1  = $random(seed);
      mac = {r1[15:0], r0};
      mac[40] = 1'b0;              // group bit off, never broadcast
      mac[IDX_W-1:0] = idx[IDX_W-1:0];
   endtask

   // ---------------------------------------------------------------------
   // reference model
   // ---------------------------------------------------------------------
   function automatic logic [4:0] expected_dport(input logic [47:0] d, input logic [1:0] sp);
      logic [IDX_W-1:0] di;
      logic [4:0]       flood;
      di    = d[IDX_W-1:0];
      flood = 5'b01111 & ~(5'b00001 << sp); // all ports but the source
      if (d == own_mac)
         return DP_SWITCH;
      else if (d == BCAST || !ref_valid[di] || ref_mac[di] != d)
         return flood;
      return 5'b00001 << ref_port[di];
   endfunction

   task automatic run_lookup(input logic [47:0] d, input logic [47:0] s, input logic [1:0] sp);
      logic [31:0]      stamp;
      logic [31:0]      status;
      logic [31:0]      data;
      logic [IDX_W-1:0] si;
      logic             evict;
      si    = s[IDX_W-1:0];
      evict = ref_valid[si] && ref_mac[si] != s;
      write_mac(AL_FRM_D_ADDR_L, AL_FRM_D_ADDR_U, d);
      write_mac(AL_FRM_S_ADDR_L, AL_FRM_S_ADDR_U, s);
      write_reg(AL_S_PORT, {30'd0, sp});
      read_reg(AL_CUR_TIME, stamp);             // stamp can only be later
      write_reg(AL_COMMAND, {30'd0, CMD_ADDR_CHECK});
      wait_idle(status);                        // idle read also clears reused
      expect_eq("status reused", status[ST_REUSED], evict);
      read_reg(AL_D_PORT, data);
      expect_eq("d_port", data, expected_dport(d, sp)); // table before learning
      if (evict)
      begin
         exp_inv_mac  = ref_mac[si];
         exp_inv_port = ref_port[si];
      end
      ref_valid[si] = 1'b1;
      ref_mac[si]   = s;
      ref_port[si]  = sp;
      ref_stamp[si] = stamp;
   endtask

   task automatic sweep_aged(input logic [31:0] bb_age);
      logic [31:0] now;
      logic [31:0] status;
      int          i;
      read_reg(AL_CUR_TIME, now);
      write_reg(AL_COMMAND, {30'd0, CMD_INVAL_AGED});
      wait_idle(status);
      expect_eq("status reused", status[ST_REUSED], 1'b0);
      for (i = 0; i < ENTRIES; i++)
      begin
         if (ref_valid[i] && (now - ref_stamp[i]) > bb_age)
         begin
            ref_valid[i] = 1'b0;
            exp_inv_mac  = ref_mac[i];   // ascending, so highest index stays
            exp_inv_port = ref_port[i];
         end
      end
   endtask

   task automatic check_last_inv();
      check_reg(AL_LST_INV_ADDR_L, exp_inv_mac[31:0]);
      check_reg(AL_LST_INV_ADDR_U, {16'd0, exp_inv_mac[47:32]});
      check_reg(AL_LST_INV_PORT, {30'd0, exp_inv_port});
   endtask

   // ---------------------------------------------------------------------
   // test sequence
   // ---------------------------------------------------------------------
   initial
   begin
      logic [7:0]  off;
      logic [31:0] t0;
      logic [31:0] t1;
      logic [31:0] data;
      logic [47:0] mac_a, mac_b, mac_u, mac_x, mac_y, mac_c;
      seed        = 32'hc604;
      n_p_reset22 = 1'b0;
      psel        = 1'b0;
      penable     = 1'b0;
      pwrite      = 1'b0;
      paddr       = '0;
      pwdata      = '0;
      for (int i = 0; i < ENTRIES; i++)
         ref_valid[i] = 1'b0;
      exp_inv_mac  = '0;
      exp_inv_port = '0;
      own_mac      = 48'h0200_5e00_0017;  // index 7, never learned
      repeat (5) @(posedge pclk22);
      #1 n_p_reset22 = 1'b1;

      // reset values, time runs so it is skipped
      for (off = 8'h00; off <= 8'h3C; off += 8'h04)
         if (off[6:0] != AL_CUR_TIME && off[6:0] != AL_BB_AGE)
            check_reg(off[6:0], 32'h0);
      check_reg(AL_BB_AGE, 32'hffff_ffff);
      check_reg(7'h40, 32'h0);              // holes
      check_reg(7'h7C, 32'h0);

      // readback, upper bits trimmed
      write_reg(AL_FRM_D_ADDR_L, 32'hcafe_0001);
      write_reg(AL_FRM_D_ADDR_U, 32'hdead_beef);
      write_reg(AL_FRM_S_ADDR_L, 32'h1234_5678);
      write_reg(AL_FRM_S_ADDR_U, 32'hffff_a5a5);
      write_reg(AL_S_PORT, 32'hffff_fffe);
      write_reg(AL_MAC_ADDR_L, own_mac[31:0]);
      write_reg(AL_MAC_ADDR_U, {16'hffff, own_mac[47:32]});
      write_reg(AL_BB_AGE, 32'h0000_1000);
      write_reg(AL_DIV_CLK, 32'h1234_5600 | TIMER_DIV);
      check_reg(AL_FRM_D_ADDR_L, 32'hcafe_0001);
      check_reg(AL_FRM_D_ADDR_U, 32'h0000_beef);
      check_reg(AL_FRM_S_ADDR_L, 32'h1234_5678);
      check_reg(AL_FRM_S_ADDR_U, 32'h0000_a5a5);
      check_reg(AL_S_PORT, 32'h2);
      check_reg(AL_MAC_ADDR_L, own_mac[31:0]);
      check_reg(AL_MAC_ADDR_U, {16'd0, own_mac[47:32]});
      check_reg(AL_BB_AGE, 32'h0000_1000);
      check_reg(AL_DIV_CLK, TIMER_DIV);

      // timer rate, samples TIMER_GAP clocks apart
      read_reg(AL_CUR_TIME, t0);
      repeat (TIMER_GAP - 3) @(posedge pclk22);
      read_reg(AL_CUR_TIME, t1);
      assert ((t1 - t0) + 1 >= TIMER_GAP / (TIMER_DIV + 1) &&
              (t1 - t0) <= TIMER_GAP / (TIMER_DIV + 1) + 1)
      else
         stop_on_error($sformatf("MISMATCH curr_time delta got %h expected %h",
                                 t1 - t0, TIMER_GAP / (TIMER_DIV + 1)));

      // destination lookup
      make_mac(2, mac_a);
      make_mac(4, mac_b);
      make_mac(6, mac_u);
      make_mac(3, mac_x);
      make_mac(3, mac_y);
      make_mac(5, mac_c);
      run_lookup(own_mac, mac_a, 2'd2);     // to the switch itself
      run_lookup(mac_u, mac_b, 2'd1);       // unknown, flood
      run_lookup(BCAST, mac_b, 2'd1);
      run_lookup(mac_a, mac_b, 2'd1);       // learned, one-hot

      // reuse of index 3
      run_lookup(BCAST, mac_x, 2'd3);
      run_lookup(BCAST, mac_y, 2'd0);
      check_last_inv();
      read_reg(AL_STATUS, data);
      expect_eq("status", data, 32'h0);

      // aging
      write_reg(AL_BB_AGE, AGE_LIMIT);
      repeat (AGE_WAIT) @(posedge pclk22);
      run_lookup(BCAST, mac_c, 2'd1);       // fresh entry
      sweep_aged(AGE_LIMIT);
      check_last_inv();
      run_lookup(mac_a, mac_c, 2'd1);
      run_lookup(mac_b, mac_c, 2'd1);
      run_lookup(mac_c, mac_c, 2'd1);       // survived the sweep

      $display("Everything OK");
      $finish;
   end

endmodule

`default_nettype wire

// ==== src/alut.sv ====
// alut address lookup unit
`default_nettype none

module alut
   import alut_table_pkg::*;
#(
   parameter int ENTRIES = 8
)
(
   input  logic        pclk22,
   input  logic        n_p_reset22,
   input  logic        psel,
   input  logic        penable,
   input  logic        pwrite,
   input  logic [6:0]  paddr,
   input  logic [31:0] pwdata,
   output logic [31:0] prdata
);

   localparam int IDX_W = $clog2(ENTRIES);

   // ---------------------------------------------------------------------
   // register bank outputs
   // ---------------------------------------------------------------------
   logic [MAC_W-1:0]   mac_addr, d_addr, s_addr;
   logic [PORT_W-1:0]  s_port;
   logic [TIME_W-1:0]  best_bfr_age, curr_time;
   logic [7:0]         div_clk;
   logic [1:0]         command;
   logic               clear_reused;

   // checker status and results
   logic               add_check_active, age_check_active, inval_in_prog, reused;
   logic [DPORT_W-1:0] d_port;
   logic [MAC_W-1:0]   lst_inv_addr_nrm, lst_inv_addr_cmd;
   logic [PORT_W-1:0]  lst_inv_port_nrm, lst_inv_port_cmd;

   // table port a, address checker
   logic [IDX_W-1:0]   a_rd_idx0, a_rd_idx1, a_wr_idx;
   logic               a_wr, a_rd_valid0, a_rd_valid1;
   logic [MAC_W-1:0]   a_wr_mac, a_rd_mac0, a_rd_mac1;
   logic [PORT_W-1:0]  a_wr_port, a_rd_port0, a_rd_port1;
   logic [TIME_W-1:0]  a_wr_stamp;

   // table port b, age checker
   logic [IDX_W-1:0]   b_rd_idx, b_clr_idx;
   logic               b_clr, b_rd_valid;
   logic [MAC_W-1:0]   b_rd_mac;
   logic [PORT_W-1:0]  b_rd_port;
   logic [TIME_W-1:0]  b_rd_stamp;

   alut_reg_bank u_reg_bank (.*);

   alut_timer u_timer (.*);

   alut_mem #(.ENTRIES(ENTRIES)) u_mem (.*);

   alut_addr_checker #(.ENTRIES(ENTRIES)) u_addr_checker (.*);

   alut_age_checker #(.ENTRIES(ENTRIES)) u_age_checker (.*);

endmodule

`default_nettype wire

// ==== src/alut_age_checker.sv ====
// alut aged entry sweep
`default_nettype none

module alut_age_checker
   import alut_table_pkg::*;
#(
   parameter int ENTRIES = 8
)
(
   input  logic                       pclk22,
   input  logic                       n_p_reset22,
   input  logic [1:0]                 command,
   input  logic [TIME_W-1:0]          curr_time,
   input  logic [TIME_W-1:0]          best_bfr_age,
   input  logic                       b_rd_valid,
   input  logic [MAC_W-1:0]           b_rd_mac,
   input  logic [PORT_W-1:0]          b_rd_port,
   input  logic [TIME_W-1:0]          b_rd_stamp,
   output logic [$clog2(ENTRIES)-1:0] b_rd_idx,
   output logic                       b_clr,
   output logic [$clog2(ENTRIES)-1:0] b_clr_idx,
   output logic                       age_check_active,
   output logic                       inval_in_prog,
   output logic [MAC_W-1:0]           lst_inv_addr_cmd,
   output logic [PORT_W-1:0]          lst_inv_port_cmd
);

   localparam int IDX_W = $clog2(ENTRIES);

   localparam logic [1:0] S_IDLE  = 2'd0;
   localparam logic [1:0] S_SCAN  = 2'd1; // entry idx on the read port
   localparam logic [1:0] S_INVAL = 2'd2; // clear entry idx

   logic [1:0]       state;
   logic [IDX_W-1:0] idx;
   logic             aged;
   logic             last;

   // wrapping difference handles timer rollover
   assign aged = b_rd_valid && ((curr_time - b_rd_stamp) > best_bfr_age);
   assign last = (idx == IDX_W'(ENTRIES - 1));

   // re-read idx while it is being cleared, otherwise fetch the next one
   always_comb
   begin
      if (state == S_IDLE)
         b_rd_idx = '0;
      else if (state == S_SCAN && aged)
         b_rd_idx = idx;
      else
         b_rd_idx = idx + 1'b1;
   end

   assign b_clr            = (state == S_INVAL);
   assign b_clr_idx        = idx;
   assign inval_in_prog    = (state == S_INVAL);
   assign age_check_active = (command == CMD_INVAL_AGED) || (state == S_SCAN);

   always_ff @(posedge pclk22 or negedge n_p_reset22)
   begin
      if (!n_p_reset22)
      begin
         state <= S_IDLE;
         idx   <= '0;
      end
      else
      begin
         case (state)
            S_IDLE  : if (command == CMD_INVAL_AGED) state <= S_SCAN;
            S_SCAN  :
            begin
               if (aged)
                  state <= S_INVAL;
               else
               begin
                  idx <= idx + 1'b1;
                  if (last)
                     state <= S_IDLE; // sweep done
               end
            end
            default :
            begin
               idx   <= idx + 1'b1;
               state <= last ? S_IDLE : S_SCAN;
            end
         endcase
      end
   end

   // stored a cycle early so the register bank sees it during the clear
   always_ff @(posedge pclk22)
   begin
      if (state == S_SCAN && aged)
      begin
         lst_inv_addr_cmd <= b_rd_mac;
         lst_inv_port_cmd <= b_rd_port;
      end
   end

   a_scan_xor_inval : assert property (@(posedge pclk22) disable iff (!n_p_reset22)
      !(age_check_active && inval_in_prog));

endmodule

`default_nettype wire

// ==== src/alut_addr_checker.sv ====
// alut destination lookup and learning
`default_nettype none

module alut_addr_checker
   import alut_table_pkg::*;
#(
   parameter int ENTRIES = 8
)
(
   input  logic                       pclk22,
   input  logic                       n_p_reset22,
   input  logic [1:0]                 command,
   input  logic [MAC_W-1:0]           d_addr,
   input  logic [MAC_W-1:0]           s_addr,
   input  logic [PORT_W-1:0]          s_port,
   input  logic [MAC_W-1:0]           mac_addr,
   input  logic [TIME_W-1:0]          curr_time,
   input  logic                       clear_reused,
   input  logic                       a_rd_valid0,
   input  logic [MAC_W-1:0]           a_rd_mac0,
   input  logic [PORT_W-1:0]          a_rd_port0,
   input  logic                       a_rd_valid1,
   input  logic [MAC_W-1:0]           a_rd_mac1,
   input  logic [PORT_W-1:0]          a_rd_port1,
   output logic [$clog2(ENTRIES)-1:0] a_rd_idx0,
   output logic [$clog2(ENTRIES)-1:0] a_rd_idx1,
   output logic                       a_wr,
   output logic [$clog2(ENTRIES)-1:0] a_wr_idx,
   output logic [MAC_W-1:0]           a_wr_mac,
   output logic [PORT_W-1:0]          a_wr_port,
   output logic [TIME_W-1:0]          a_wr_stamp,
   output logic                       add_check_active,
   output logic [DPORT_W-1:0]         d_port,
   output logic                       reused,
   output logic [MAC_W-1:0]           lst_inv_addr_nrm,
   output logic [PORT_W-1:0]          lst_inv_port_nrm
);

   localparam int IDX_W = $clog2(ENTRIES);

   localparam logic [1:0] S_IDLE  = 2'd0;
   localparam logic [1:0] S_LOOK  = 2'd1; // read data back from the table
   localparam logic [1:0] S_LEARN = 2'd2; // write source entry

   logic [1:0]         state;
   logic [DPORT_W-1:0] flood;
   logic [DPORT_W-1:0] d_port_nxt;

   // table index is just the low address bits
   assign a_rd_idx0  = d_addr[IDX_W-1:0];
   assign a_rd_idx1  = s_addr[IDX_W-1:0];
   assign a_wr       = (state == S_LEARN);
   assign a_wr_idx   = s_addr[IDX_W-1:0];
   assign a_wr_mac   = s_addr;
   assign a_wr_port  = s_port;
   assign a_wr_stamp = curr_time;

   // busy from the command pulse onwards so status never shows a gap
   assign add_check_active = (command == CMD_ADDR_CHECK) || (state != S_IDLE);

   // ---------------------------------------------------------------------
   // destination decision
   // ---------------------------------------------------------------------
   always_comb
   begin
      flood         = {1'b0, {(DPORT_W-1){1'b1}}};
      flood[s_port] = 1'b0;                 // never back out the source port
      if (d_addr == mac_addr)
         d_port_nxt = DP_SWITCH;
      else if ((&d_addr) || !a_rd_valid0 || a_rd_mac0 != d_addr)
         d_port_nxt = flood;                 // broadcast or unknown
      else
         d_port_nxt = DPORT_W'(1) << a_rd_port0;
   end

   always_ff @(posedge pclk22 or negedge n_p_reset22)
   begin
      if (!n_p_reset22)
      begin
         state  <= S_IDLE;
         d_port <= '0;
         reused <= 1'b0;
      end
      else
      begin
         case (state)
            S_IDLE  : if (command == CMD_ADDR_CHECK) state <= S_LOOK;
            S_LOOK  :
            begin
               d_port <= d_port_nxt;   // held until the next check
               if (a_rd_valid1 && a_rd_mac1 != s_addr)
                  reused <= 1'b1;      // learning evicts another address
               state <= S_LEARN;
            end
            default :
               state <= S_IDLE;
         endcase
         if (state == S_IDLE && clear_reused)
            reused <= 1'b0;
      end
   end

   // evicted entry, payload only
   always_ff @(posedge pclk22)
   begin
      if (state == S_LOOK && a_rd_valid1 && a_rd_mac1 != s_addr)
      begin
         lst_inv_addr_nrm <= a_rd_mac1;
         lst_inv_port_nrm <= a_rd_port1;
      end
   end

   // a finished check always selects some port
   a_dport_set : assert property (@(posedge pclk22) disable iff (!n_p_reset22)
      (state == S_LEARN) |-> d_port != '0);

endmodule

`default_nettype wire

// ==== src/alut_mem.sv ====
// alut address table storage
`default_nettype none

module alut_mem
   import alut_table_pkg::*;
#(
   parameter int ENTRIES = 8
)
(
   input  logic                       pclk22,
   input  logic                       n_p_reset22,
   input  logic [$clog2(ENTRIES)-1:0] a_rd_idx0,
   input  logic [$clog2(ENTRIES)-1:0] a_rd_idx1,
   input  logic                       a_wr,
   input  logic [$clog2(ENTRIES)-1:0] a_wr_idx,
   input  logic [MAC_W-1:0]           a_wr_mac,
   input  logic [PORT_W-1:0]          a_wr_port,
   input  logic [TIME_W-1:0]          a_wr_stamp,
   input  logic [$clog2(ENTRIES)-1:0] b_rd_idx,
   input  logic                       b_clr,
   input  logic [$clog2(ENTRIES)-1:0] b_clr_idx,
   output logic                       a_rd_valid0,
   output logic [MAC_W-1:0]           a_rd_mac0,
   output logic [PORT_W-1:0]          a_rd_port0,
   output logic                       a_rd_valid1,
   output logic [MAC_W-1:0]           a_rd_mac1,
   output logic [PORT_W-1:0]          a_rd_port1,
   output logic                       b_rd_valid,
   output logic [MAC_W-1:0]           b_rd_mac,
   output logic [PORT_W-1:0]          b_rd_port,
   output logic [TIME_W-1:0]          b_rd_stamp
);

   logic [ENTRIES-1:0] valid;                 // one bit per entry
   logic [MAC_W-1:0]   mac_mem   [ENTRIES];
   logic [PORT_W-1:0]  port_mem  [ENTRIES];
   logic [TIME_W-1:0]  stamp_mem [ENTRIES];

   // valid bits and their read copies
   always_ff @(posedge pclk22 or negedge n_p_reset22)
   begin
      if (!n_p_reset22)
      begin
         valid       <= '0;  // table starts empty
         a_rd_valid0 <= 1'b0;
         a_rd_valid1 <= 1'b0;
         b_rd_valid  <= 1'b0;
      end
      else
      begin
         a_rd_valid0 <= valid[a_rd_idx0]; // old value on collision
         a_rd_valid1 <= valid[a_rd_idx1];
         b_rd_valid  <= valid[b_rd_idx];
         if (a_wr)
            valid[a_wr_idx] <= 1'b1;
         if (b_clr)
            valid[b_clr_idx] <= 1'b0;
      end
   end

   // entry payload
   always_ff @(posedge pclk22)
   begin
      a_rd_mac0  <= mac_mem[a_rd_idx0];
      a_rd_port0 <= port_mem[a_rd_idx0];
      a_rd_mac1  <= mac_mem[a_rd_idx1];
      a_rd_port1 <= port_mem[a_rd_idx1];
      b_rd_mac   <= mac_mem[b_rd_idx];
      b_rd_port  <= port_mem[b_rd_idx];
      b_rd_stamp <= stamp_mem[b_rd_idx];
      if (a_wr)
      begin
         mac_mem[a_wr_idx]   <= a_wr_mac;
         port_mem[a_wr_idx]  <= a_wr_port;
         stamp_mem[a_wr_idx] <= a_wr_stamp;
      end
   end

   // learning and the sweep never touch the same entry at once
   a_no_wr_clr : assert property (@(posedge pclk22) disable iff (!n_p_reset22)
      !(a_wr && b_clr && a_wr_idx == b_clr_idx));

endmodule

`default_nettype wire

// ==== src/alut_timer.sv ====
// alut time stamp counter
`default_nettype none

module alut_timer
(
   input  logic        pclk22,
   input  logic        n_p_reset22,
   input  logic [7:0]  div_clk,
   output logic [31:0] curr_time
);

   logic [7:0] presc;    // prescaler count
   logic [7:0] div_lat;  // divider in use for this period

   // time advances once per div_lat+1 clocks
   always_ff @(posedge pclk22 or negedge n_p_reset22)
   begin
      if (!n_p_reset22)
      begin
         presc     <= '0;
         div_lat   <= '0;
         curr_time <= '0;
      end
      else if (presc == div_lat)
      begin
         presc     <= '0;
         div_lat   <= div_clk;        // new divider picked up on wrap
         curr_time <= curr_time + 1'b1; // wraps freely
      end
      else
         presc <= presc + 1'b1;
   end

endmodule

`default_nettype wire

// ==== src/alut_reg_bank.sv ====
// alut apb register bank
`default_nettype none

module alut_reg_bank
   import alut_regmap_pkg::*, alut_table_pkg::*;
(
   input  logic               pclk22,
   input  logic               n_p_reset22,
   input  logic               psel,
   input  logic               penable,
   input  logic               pwrite,
   input  logic [6:0]         paddr,
   input  logic [31:0]        pwdata,
   input  logic [TIME_W-1:0]  curr_time,
   input  logic               add_check_active,
   input  logic               age_check_active,
   input  logic               inval_in_prog,
   input  logic               reused,
   input  logic [DPORT_W-1:0] d_port,
   input  logic [MAC_W-1:0]   lst_inv_addr_nrm,
   input  logic [PORT_W-1:0]  lst_inv_port_nrm,
   input  logic [MAC_W-1:0]   lst_inv_addr_cmd,
   input  logic [PORT_W-1:0]  lst_inv_port_cmd,
   output logic [MAC_W-1:0]   mac_addr,
   output logic [MAC_W-1:0]   d_addr,
   output logic [MAC_W-1:0]   s_addr,
   output logic [PORT_W-1:0]  s_port,
   output logic [TIME_W-1:0]  best_bfr_age,
   output logic [7:0]         div_clk,
   output logic [1:0]         command,
   output logic [31:0]        prdata,
   output logic               clear_reused
);

   logic              read_enable;   // setup phase of a read
   logic              write_enable;  // access phase of a write
   logic              active;
   logic [31:0]       frm_d_addr_l;
   logic [15:0]       frm_d_addr_u;
   logic [31:0]       frm_s_addr_l;
   logic [15:0]       frm_s_addr_u;
   logic [31:0]       mac_addr_l;
   logic [15:0]       mac_addr_u;
   logic [MAC_W-1:0]  lst_inv_addr;
   logic [PORT_W-1:0] lst_inv_port;

   assign read_enable  = psel & ~penable & ~pwrite;
   assign write_enable = psel & penable & pwrite;
   assign active       = add_check_active | age_check_active;

   assign mac_addr = {mac_addr_u, mac_addr_l};
   assign d_addr   = {frm_d_addr_u, frm_d_addr_l};
   assign s_addr   = {frm_s_addr_u, frm_s_addr_l};

   // status read while idle clears the sticky reused flag
   assign clear_reused = read_enable & (paddr == AL_STATUS) & ~active;

   // ---------------------------------------------------------------------
   // read mux, registered so data shows in the access phase
   // ---------------------------------------------------------------------
   always_ff @(posedge pclk22 or negedge n_p_reset22)
   begin
      if (!n_p_reset22)
         prdata <= '0;
      else if (read_enable)
      begin
         case (paddr)
            AL_FRM_D_ADDR_L   : prdata <= frm_d_addr_l;
            AL_FRM_D_ADDR_U   : prdata <= {16'd0, frm_d_addr_u};
            AL_FRM_S_ADDR_L   : prdata <= frm_s_addr_l;
            AL_FRM_S_ADDR_U   : prdata <= {16'd0, frm_s_addr_u};
            AL_S_PORT         : prdata <= {30'd0, s_port};
            AL_D_PORT         : prdata <= {27'd0, d_port};
            AL_MAC_ADDR_L     : prdata <= mac_addr_l;
            AL_MAC_ADDR_U     : prdata <= {16'd0, mac_addr_u};
            AL_CUR_TIME       : prdata <= curr_time;
            AL_BB_AGE         : prdata <= best_bfr_age;
            AL_DIV_CLK        : prdata <= {24'd0, div_clk};
            AL_STATUS         : prdata <= {29'd0, reused, inval_in_prog, active};
            AL_LST_INV_ADDR_L : prdata <= lst_inv_addr[31:0];
            AL_LST_INV_ADDR_U : prdata <= {16'd0, lst_inv_addr[47:32]};
            AL_LST_INV_PORT   : prdata <= {30'd0, lst_inv_port};
            default           : prdata <= '0; // command and holes
         endcase
      end
      else
         prdata <= '0; // bus idles at zero
   end

   // ---------------------------------------------------------------------
   // writable registers
   // ---------------------------------------------------------------------
   always_ff @(posedge pclk22 or negedge n_p_reset22)
   begin
      if (!n_p_reset22)
      begin
         frm_d_addr_l <= '0;
         frm_d_addr_u <= '0;
         frm_s_addr_l <= '0;
         frm_s_addr_u <= '0;
         s_port       <= '0;
         mac_addr_l   <= '0;
         mac_addr_u   <= '0;
         best_bfr_age <= '1;  // nothing ages until programmed
         div_clk      <= '0;
      end
      else if (write_enable)
      begin
         case (paddr)
            AL_FRM_D_ADDR_L : frm_d_addr_l <= pwdata;
            AL_FRM_D_ADDR_U : frm_d_addr_u <= pwdata[15:0];
            AL_FRM_S_ADDR_L : frm_s_addr_l <= pwdata;
            AL_FRM_S_ADDR_U : frm_s_addr_u <= pwdata[15:0];
            AL_S_PORT       : s_port       <= pwdata[PORT_W-1:0];
            AL_MAC_ADDR_L   : mac_addr_l   <= pwdata;
            AL_MAC_ADDR_U   : mac_addr_u   <= pwdata[15:0];
            AL_BB_AGE       : best_bfr_age <= pwdata;
            AL_DIV_CLK      : div_clk      <= pwdata[7:0];
            default         : ;
         endcase
      end
   end

   // command pulse, one cycle then back to none
   always_ff @(posedge pclk22 or negedge n_p_reset22)
   begin
      if (!n_p_reset22)
         command <= CMD_NONE;
      else if (command != CMD_NONE)
         command <= CMD_NONE;      // write landing here is dropped
      else if (write_enable && paddr == AL_COMMAND)
         command <= pwdata[1:0];
   end

   // ---------------------------------------------------------------------
   // last invalidated entry, eviction by learning wins over the sweep
   // ---------------------------------------------------------------------
   always_ff @(posedge pclk22 or negedge n_p_reset22)
   begin
      if (!n_p_reset22)
      begin
         lst_inv_addr <= '0;
         lst_inv_port <= '0;
      end
      else if (reused)
      begin
         lst_inv_addr <= lst_inv_addr_nrm;
         lst_inv_port <= lst_inv_port_nrm;
      end
      else if (inval_in_prog)
      begin
         lst_inv_addr <= lst_inv_addr_cmd;
         lst_inv_port <= lst_inv_port_cmd;
      end
   end

   // read data decoded in setup belongs to the access that follows
   a_apb_setup : assert property (@(posedge pclk22) disable iff (!n_p_reset22)
      (psel && !penable) |=> (psel && penable && $stable(paddr) && $stable(pwrite)));

   // a command written while both checkers idle is never lost
   a_cmd_wr : assert property (@(posedge pclk22) disable iff (!n_p_reset22)
      (write_enable && paddr == AL_COMMAND && !active)
      |=> command == $past(pwdata[1:0]));

endmodule

`default_nettype wire

// ==== src/alut_table_pkg.sv ====
// alut lookup table definitions
`default_nettype none

package alut_table_pkg;

   // field widths
   localparam int MAC_W   = 48; // ethernet address
   localparam int PORT_W  = 2;  // four ports
   localparam int TIME_W  = 32; // time stamp
   localparam int DPORT_W = 5;  // port mask, bit 4 is the switch

   // port mask for frames addressed to the switch itself
   localparam logic [DPORT_W-1:0] DP_SWITCH = 5'b1_0000;

   // ---------------------------------------------------------------------
   // command codes, written to AL_COMMAND
   // ---------------------------------------------------------------------
   localparam logic [1:0] CMD_NONE       = 2'd0;
   localparam logic [1:0] CMD_INVAL_AGED = 2'd1; // sweep out old entries
   localparam logic [1:0] CMD_ADDR_CHECK = 2'd2; // lookup and learn

endpackage

`default_nettype wire

// ==== src/alut_regmap_pkg.sv ====
// alut apb register map
`default_nettype none

package alut_regmap_pkg;

   // ---------------------------------------------------------------------
   // register offsets, byte addresses
   // ---------------------------------------------------------------------
   localparam logic [6:0] AL_FRM_D_ADDR_L   = 7'h00; // dest addr [31:0]
   localparam logic [6:0] AL_FRM_D_ADDR_U   = 7'h04; // dest addr [47:32]
   localparam logic [6:0] AL_FRM_S_ADDR_L   = 7'h08; // src addr [31:0]
   localparam logic [6:0] AL_FRM_S_ADDR_U   = 7'h0C; // src addr [47:32]
   localparam logic [6:0] AL_S_PORT         = 7'h10;
   localparam logic [6:0] AL_D_PORT         = 7'h14; // read only, lookup result
   localparam logic [6:0] AL_MAC_ADDR_L     = 7'h18; // switch own address
   localparam logic [6:0] AL_MAC_ADDR_U     = 7'h1C;
   localparam logic [6:0] AL_CUR_TIME       = 7'h20; // read only
   localparam logic [6:0] AL_BB_AGE         = 7'h24;
   localparam logic [6:0] AL_DIV_CLK        = 7'h28;
   localparam logic [6:0] AL_STATUS         = 7'h2C; // read clears reused
   localparam logic [6:0] AL_LST_INV_ADDR_L = 7'h30;
   localparam logic [6:0] AL_LST_INV_ADDR_U = 7'h34;
   localparam logic [6:0] AL_LST_INV_PORT   = 7'h38;
   localparam logic [6:0] AL_COMMAND        = 7'h3C; // write only

   // status bits
   localparam int ST_ACTIVE = 0; // check or sweep busy
   localparam int ST_INVAL  = 1; // invalidation in progress
   localparam int ST_REUSED = 2; // entry evicted by learning

endpackage

`default_nettype wire
